/* rtl/ahb_data_phase.sv */
`timescale 1ns/100ps

/* Data-phase tracking for the shared slave. Write data follows the port of
   the last accepted address phase; ready is forced high when not selected */
module ahb_data_phase (
  input  logic                    HCLK,           // AHB clock
  input  logic                    HRESETn,        // Sync reset, active low
  input  ahb_out_pkg::port_code_e i_addr_in_port, // Address-phase grant
  input  logic                    i_hselm,        // Muxed select
  input  logic                    i_hreadyoutm,   // Ready from the slave
  input  ahb_out_pkg::hdata_t     i_wdata_op0,
  input  ahb_out_pkg::hdata_t     i_wdata_op2,
  input  ahb_out_pkg::hdata_t     i_wdata_op3,
  output logic                    o_hreadymuxm,   // Transfer advance strobe
  output ahb_out_pkg::hdata_t     o_hwdatam       // Write data to the slave
);

  ahb_out_pkg::port_code_e data_in_port; // Owner of the data phase
  logic                    slave_sel;    // Slave selected in data phase

  // ----------------------------------------------------------
  // Data-phase registers
  // ----------------------------------------------------------
  always_ff @(posedge HCLK)
  begin
    if (!HRESETn)
    begin
      data_in_port <= ahb_out_pkg::PORT0;
      slave_sel    <= 1'b0;
    end
    else if (o_hreadymuxm)
    begin
      data_in_port <= i_addr_in_port;  // Address phase moves to data phase
      slave_sel    <= i_hselm;
    end
  end

  // Slave ready only counts when it owns the data phase
  assign o_hreadymuxm = slave_sel ? i_hreadyoutm : 1'b1;

  // ----------------------------------------------------------
  // Write data mux
  // ----------------------------------------------------------
  always_comb
  begin
    case (data_in_port)
      ahb_out_pkg::PORT0: o_hwdatam = i_wdata_op0;
      ahb_out_pkg::PORT2: o_hwdatam = i_wdata_op2;
      ahb_out_pkg::PORT3: o_hwdatam = i_wdata_op3;
      default:            o_hwdatam = '0;  // Unused code
    endcase
  end

endmodule

/* rtl/ahb_out_arbiter.sv */
`timescale 1ns/100ps

/* Round-robin arbiter, order 0, 2, 3, 0. Grant is held only during locked
   sequences; all state moves only when i_hreadym is high */
module ahb_out_arbiter (
  input  logic                    HCLK,           // AHB clock
  input  logic                    HRESETn,        // Sync reset, active low
  input  logic                    i_req_port0,    // Port 0 wants the slave
  input  logic                    i_req_port2,    // Port 2 wants the slave
  input  logic                    i_req_port3,    // Port 3 wants the slave
  input  logic                    i_hreadym,      // Transfer advance strobe
  input  logic                    i_hselm,        // Muxed select
  input  ahb_out_pkg::htrans_t    i_htransm,      // Muxed transfer type
  input  logic                    i_hmastlockm,   // Muxed master lock
  output ahb_out_pkg::port_code_e o_addr_in_port, // Granted port
  output logic                    o_no_port       // Nothing granted
);

  logic                    hsel_lock;      // Locked sequence under way here
  logic                    next_hsel_lock;
  logic                    hlock_arb;      // Lock masked by select
  ahb_out_pkg::port_code_e next_port;
  logic                    next_no_port;

  // ----------------------------------------------------------
  // Lock tracking
  // ----------------------------------------------------------
  // A locked master may address another region mid-sequence with its
  // select low; hsel_lock keeps the slave reserved through those cycles.
  always_comb
  begin
    if (i_hselm && i_htransm[ahb_out_pkg::HTRANS_ACTIVE_BIT] && i_hmastlockm)
      next_hsel_lock = 1'b1;       // Locked transfer accepted here
    else if (!i_hmastlockm)
      next_hsel_lock = 1'b0;       // Sequence over
    else
      next_hsel_lock = hsel_lock;
  end

  assign hlock_arb = i_hmastlockm & (hsel_lock | i_hselm);

  // ----------------------------------------------------------
  // Next grant
  // ----------------------------------------------------------
  always_comb
  begin
    next_port    = o_addr_in_port;  // Hold by default
    next_no_port = 1'b0;
    if (hlock_arb)
      next_no_port = o_no_port;     // Locked, keep everything
    else
    begin
      case (o_addr_in_port)
        ahb_out_pkg::PORT2:
        begin
          if (i_req_port3)
            next_port = ahb_out_pkg::PORT3;
          else if (i_req_port0)
            next_port = ahb_out_pkg::PORT0;
          else if (i_req_port2)
            next_port = ahb_out_pkg::PORT2;
          else
            next_no_port = 1'b1;    // Idle, grant stays
        end
        ahb_out_pkg::PORT3:
        begin
          if (i_req_port0)
            next_port = ahb_out_pkg::PORT0;
          else if (i_req_port2)
            next_port = ahb_out_pkg::PORT2;
          else if (i_req_port3)
            next_port = ahb_out_pkg::PORT3;
          else
            next_no_port = 1'b1;
        end
        default:                    // PORT0
        begin
          if (i_req_port2)
            next_port = ahb_out_pkg::PORT2;
          else if (i_req_port3)
            next_port = ahb_out_pkg::PORT3;
          else if (i_req_port0)
            next_port = ahb_out_pkg::PORT0;
          else
            next_no_port = 1'b1;
        end
      endcase
    end
  end

  // ----------------------------------------------------------
  // State registers
  // ----------------------------------------------------------
  always_ff @(posedge HCLK)
  begin
    if (!HRESETn)
    begin
      hsel_lock      <= 1'b0;
      o_addr_in_port <= ahb_out_pkg::PORT0;
      o_no_port      <= 1'b1;  // Start with the slave unowned
    end
    else if (i_hreadym)
    begin
      hsel_lock      <= next_hsel_lock;
      o_addr_in_port <= next_port;
      o_no_port      <= next_no_port;
    end
  end

endmodule

/* rtl/ahb_out_mux.sv */
`timescale 1ns/100ps

/* Combinational address/control mux onto the slave. Outputs are all zero
   while no port is granted or for the unused code 2'b01 */
module ahb_out_mux (
  input  ahb_out_pkg::port_code_e i_addr_in_port, // Granted port
  input  logic                    i_no_port,      // Nothing granted
  input  logic                    i_sel_op0,
  input  ahb_out_pkg::haddr_t     i_addr_op0,
  input  ahb_out_pkg::htrans_t    i_trans_op0,
  input  logic                    i_write_op0,
  input  ahb_out_pkg::hsize_t     i_size_op0,
  input  ahb_out_pkg::hburst_t    i_burst_op0,
  input  ahb_out_pkg::hprot_t     i_prot_op0,
  input  ahb_out_pkg::hmaster_t   i_master_op0,
  input  logic                    i_mastlock_op0,
  input  logic                    i_sel_op2,
  input  ahb_out_pkg::haddr_t     i_addr_op2,
  input  ahb_out_pkg::htrans_t    i_trans_op2,
  input  logic                    i_write_op2,
  input  ahb_out_pkg::hsize_t     i_size_op2,
  input  ahb_out_pkg::hburst_t    i_burst_op2,
  input  ahb_out_pkg::hprot_t     i_prot_op2,
  input  ahb_out_pkg::hmaster_t   i_master_op2,
  input  logic                    i_mastlock_op2,
  input  logic                    i_sel_op3,
  input  ahb_out_pkg::haddr_t     i_addr_op3,
  input  ahb_out_pkg::htrans_t    i_trans_op3,
  input  logic                    i_write_op3,
  input  ahb_out_pkg::hsize_t     i_size_op3,
  input  ahb_out_pkg::hburst_t    i_burst_op3,
  input  ahb_out_pkg::hprot_t     i_prot_op3,
  input  ahb_out_pkg::hmaster_t   i_master_op3,
  input  logic                    i_mastlock_op3,
  output logic                    o_hselm,
  output ahb_out_pkg::haddr_t     o_haddrm,
  output ahb_out_pkg::htrans_t    o_htransm,
  output logic                    o_hwritem,
  output ahb_out_pkg::hsize_t     o_hsizem,
  output ahb_out_pkg::hburst_t    o_hburstm,
  output ahb_out_pkg::hprot_t     o_hprotm,
  output ahb_out_pkg::hmaster_t   o_hmasterm,
  output logic                    o_hmastlockm,
  output logic                    o_active_op0,   // Port 0 owns the slave
  output logic                    o_active_op2,   // Port 2 owns the slave
  output logic                    o_active_op3    // Port 3 owns the slave
);

  // ----------------------------------------------------------
  // Active flags, one-hot on the grant
  // ----------------------------------------------------------
  assign o_active_op0 = !i_no_port && (i_addr_in_port == ahb_out_pkg::PORT0);
  assign o_active_op2 = !i_no_port && (i_addr_in_port == ahb_out_pkg::PORT2);
  assign o_active_op3 = !i_no_port && (i_addr_in_port == ahb_out_pkg::PORT3);

  // ----------------------------------------------------------
  // Address and control mux
  // ----------------------------------------------------------
  always_comb
  begin
    o_hselm      = 1'b0;                     // Idle bus by default
    o_haddrm     = '0;
    o_htransm    = ahb_out_pkg::HTRANS_IDLE;
    o_hwritem    = 1'b0;
    o_hsizem     = '0;
    o_hburstm    = '0;
    o_hprotm     = '0;
    o_hmasterm   = '0;
    o_hmastlockm = 1'b0;
    if (!i_no_port)
    begin
      case (i_addr_in_port)
        ahb_out_pkg::PORT0:
        begin
          o_hselm      = i_sel_op0;
          o_haddrm     = i_addr_op0;
          o_htransm    = i_trans_op0;
          o_hwritem    = i_write_op0;
          o_hsizem     = i_size_op0;
          o_hburstm    = i_burst_op0;
          o_hprotm     = i_prot_op0;
          o_hmasterm   = i_master_op0;
          o_hmastlockm = i_mastlock_op0;
        end
        ahb_out_pkg::PORT2:
        begin
          o_hselm      = i_sel_op2;
          o_haddrm     = i_addr_op2;
          o_htransm    = i_trans_op2;
          o_hwritem    = i_write_op2;
          o_hsizem     = i_size_op2;
          o_hburstm    = i_burst_op2;
          o_hprotm     = i_prot_op2;
          o_hmasterm   = i_master_op2;
          o_hmastlockm = i_mastlock_op2;
        end
        ahb_out_pkg::PORT3:
        begin
          o_hselm      = i_sel_op3;
          o_haddrm     = i_addr_op3;
          o_htransm    = i_trans_op3;
          o_hwritem    = i_write_op3;
          o_hsizem     = i_size_op3;
          o_hburstm    = i_burst_op3;
          o_hprotm     = i_prot_op3;
          o_hmasterm   = i_master_op3;
          o_hmastlockm = i_mastlock_op3;
        end
        default:
          o_hselm = 1'b0;  // Code 01, keep zeros
      endcase
    end
  end

endmodule

/* rtl/ahb_out_pkg.sv */
/* Shared widths and codes for the flash output stage. The port set is fixed
   to sparse ports 0, 2 and 3, so the code 2'b01 is never granted */
package ahb_out_pkg;

  // ----------------------------------------------------------
  // Bus widths
  // ----------------------------------------------------------
  typedef logic [31:0] haddr_t;   // HADDR
  typedef logic [31:0] hdata_t;   // HWDATA
  typedef logic [1:0]  htrans_t;  // HTRANS
  typedef logic [2:0]  hsize_t;   // HSIZE
  typedef logic [2:0]  hburst_t;  // HBURST
  typedef logic [3:0]  hprot_t;   // HPROT
  typedef logic [3:0]  hmaster_t; // HMASTER

  // ----------------------------------------------------------
  // Port codes, also the arbiter state
  // ----------------------------------------------------------
  typedef enum logic [1:0] {
    PORT0 = 2'b00,  // Input port 0
    PORT2 = 2'b10,  // Input port 2
    PORT3 = 2'b11   // Input port 3
  } port_code_e;

  // ----------------------------------------------------------
  // Transfer types
  // ----------------------------------------------------------
  localparam htrans_t HTRANS_IDLE   = 2'b00; // No transfer
  localparam htrans_t HTRANS_NONSEQ = 2'b10; // First beat of a transfer

  // HTRANS[1] set means NONSEQ or SEQ, i.e. a real transfer
  localparam int HTRANS_ACTIVE_BIT = 1;

endpackage

/* rtl/ahb_out_stage.sv */
`timescale 1ns/100ps

/* Output stage for the shared flash slave, fed from sparse ports 0, 2, 3.
   One cycle from request to active; write data lags by one accepted transfer */
module ahb_out_stage (
  input  logic                  HCLK,            // AHB clock
  input  logic                  HRESETn,         // Sync reset, active low
  input  logic                  i_sel_op0,       // Port 0 selects this slave
  input  ahb_out_pkg::haddr_t   i_addr_op0,
  input  ahb_out_pkg::htrans_t  i_trans_op0,
  input  logic                  i_write_op0,
  input  ahb_out_pkg::hsize_t   i_size_op0,
  input  ahb_out_pkg::hburst_t  i_burst_op0,
  input  ahb_out_pkg::hprot_t   i_prot_op0,
  input  ahb_out_pkg::hmaster_t i_master_op0,
  input  logic                  i_mastlock_op0,
  input  ahb_out_pkg::hdata_t   i_wdata_op0,
  input  logic                  i_held_tran_op0, // Port 0 holds a transfer
  input  logic                  i_sel_op2,
  input  ahb_out_pkg::haddr_t   i_addr_op2,
  input  ahb_out_pkg::htrans_t  i_trans_op2,
  input  logic                  i_write_op2,
  input  ahb_out_pkg::hsize_t   i_size_op2,
  input  ahb_out_pkg::hburst_t  i_burst_op2,
  input  ahb_out_pkg::hprot_t   i_prot_op2,
  input  ahb_out_pkg::hmaster_t i_master_op2,
  input  logic                  i_mastlock_op2,
  input  ahb_out_pkg::hdata_t   i_wdata_op2,
  input  logic                  i_held_tran_op2,
  input  logic                  i_sel_op3,
  input  ahb_out_pkg::haddr_t   i_addr_op3,
  input  ahb_out_pkg::htrans_t  i_trans_op3,
  input  logic                  i_write_op3,
  input  ahb_out_pkg::hsize_t   i_size_op3,
  input  ahb_out_pkg::hburst_t  i_burst_op3,
  input  ahb_out_pkg::hprot_t   i_prot_op3,
  input  ahb_out_pkg::hmaster_t i_master_op3,
  input  logic                  i_mastlock_op3,
  input  ahb_out_pkg::hdata_t   i_wdata_op3,
  input  logic                  i_held_tran_op3,
  input  logic                  i_hreadyoutm,    // Slave ready
  output logic                  o_active_op0,
  output logic                  o_active_op2,
  output logic                  o_active_op3,
  output logic                  o_hselm,
  output ahb_out_pkg::haddr_t   o_haddrm,
  output ahb_out_pkg::htrans_t  o_htransm,
  output logic                  o_hwritem,
  output ahb_out_pkg::hsize_t   o_hsizem,
  output ahb_out_pkg::hburst_t  o_hburstm,
  output ahb_out_pkg::hprot_t   o_hprotm,
  output ahb_out_pkg::hmaster_t o_hmasterm,
  output logic                  o_hmastlockm,
  output logic                  o_hreadymuxm,    // Ready seen by the slave
  output ahb_out_pkg::hdata_t   o_hwdatam
);

  logic                    req_port0;    // Request = held transfer for us
  logic                    req_port2;
  logic                    req_port3;
  ahb_out_pkg::port_code_e addr_in_port; // Current grant
  logic                    no_port;
  logic                    hselm;        // Internal copies fed back
  ahb_out_pkg::htrans_t    htransm;
  logic                    hmastlockm;
  logic                    hreadymuxm;

  assign req_port0 = i_held_tran_op0 & i_sel_op0;
  assign req_port2 = i_held_tran_op2 & i_sel_op2;
  assign req_port3 = i_held_tran_op3 & i_sel_op3;

  // ----------------------------------------------------------
  // Arbitration
  // ----------------------------------------------------------
  ahb_out_arbiter u_arbiter (
    .HCLK           (HCLK),
    .HRESETn        (HRESETn),
    .i_req_port0    (req_port0),
    .i_req_port2    (req_port2),
    .i_req_port3    (req_port3),
    .i_hreadym      (hreadymuxm),
    .i_hselm        (hselm),
    .i_htransm      (htransm),
    .i_hmastlockm   (hmastlockm),
    .o_addr_in_port (addr_in_port),
    .o_no_port      (no_port)
  );

  // Port buses and the remaining slave outputs match by name
  ahb_out_mux u_mux (
    .i_addr_in_port (addr_in_port),
    .i_no_port      (no_port),
    .o_hselm        (hselm),
    .o_htransm      (htransm),
    .o_hmastlockm   (hmastlockm),
    .*
  );

  // ----------------------------------------------------------
  // Data phase
  // ----------------------------------------------------------
  ahb_data_phase u_data_phase (
    .HCLK           (HCLK),
    .HRESETn        (HRESETn),
    .i_addr_in_port (addr_in_port),
    .i_hselm        (hselm),
    .i_hreadyoutm   (i_hreadyoutm),
    .i_wdata_op0    (i_wdata_op0),
    .i_wdata_op2    (i_wdata_op2),
    .i_wdata_op3    (i_wdata_op3),
    .o_hreadymuxm   (hreadymuxm),
    .o_hwdatam      (o_hwdatam)
  );

  assign o_hselm      = hselm;
  assign o_htransm    = htransm;
  assign o_hmastlockm = hmastlockm;
  assign o_hreadymuxm = hreadymuxm;

endmodule

/* run_sim.sh */
#!/bin/sh
# Build and run the testbench with Verilator; the simulation log decides the result
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log
verilator --binary --top-module tb_ahb_out_stage -f sources.f -o tb_sim > build.log 2>&1 \
  && ./obj_dir/tb_sim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -qx "Finished with no errors" sim.log && echo "PASS" && exit 0 \
  || { echo "FAIL, see build.log and sim.log"; exit 1; }

/* sources.f */
+incdir+tb
rtl/ahb_out_pkg.sv
rtl/ahb_out_arbiter.sv
rtl/ahb_out_mux.sv
rtl/ahb_data_phase.sv
rtl/ahb_out_stage.sv
tb/tb_ahb_out_stage.sv

/* tb/ahb_out_model.svh */
`ifndef AHB_OUT_MODEL_SVH
`define AHB_OUT_MODEL_SVH

/* Cycle model of grant, lock and data phase. Include inside the testbench after
   the p_* port arrays and hready; array index 0, 1, 2 stands for ports 0, 2, 3 */

logic [1:0] m_grant;       // Granted port code
logic       m_no_port;     // Nothing granted
logic       m_lock;        // Locked sequence seen at this slave
logic [1:0] m_data_port;   // Owner of the data phase
logic       m_slave_sel;   // Slave selected in the data phase
logic       m_edge_locked; // Last edge kept the grant for a lock

// Port codes 00, 10, 11 map to array slots 0, 1, 2
function automatic int port_index(input logic [1:0] code);
  case (code)
    2'b10:   return 1;
    2'b11:   return 2;
    default: return 0;
  endcase
endfunction

function automatic logic [1:0] index_code(input int idx);
  case (idx)
    1:       return 2'b10;
    2:       return 2'b11;
    default: return 2'b00;
  endcase
endfunction

// ------------------------------------------------------------
// Expected values of the current cycle
// ------------------------------------------------------------
function automatic logic cur_sel();
  return !m_no_port && p_sel[port_index(m_grant)];
endfunction

function automatic ahb_out_pkg::htrans_t cur_trans();
  return m_no_port ? 2'b00 : p_trans[port_index(m_grant)];
endfunction

function automatic logic cur_lock();
  return !m_no_port && p_lock[port_index(m_grant)];
endfunction

function automatic logic exp_ready();
  return m_slave_sel ? hready : 1'b1;  // Slave ready counts only when selected
endfunction

function automatic logic [2:0] exp_active();
  return m_no_port ? 3'b000 : 3'b001 << port_index(m_grant);  // {op3, op2, op0}
endfunction

task automatic model_reset();
  m_grant       = 2'b00;
  m_no_port     = 1'b1;  // Slave unowned out of reset
  m_lock        = 1'b0;
  m_data_port   = 2'b00;
  m_slave_sel   = 1'b0;
  m_edge_locked = 1'b0;
endtask

// ------------------------------------------------------------
// One rising edge, called with the pre-edge inputs
// ------------------------------------------------------------
task automatic model_step();
  logic                 sel_now;
  logic                 lock_now;
  logic                 next_lock;
  ahb_out_pkg::htrans_t trans_now;
  logic                 found;
  int                   cur;
  int                   cand;
  m_edge_locked = 1'b0;
  if (exp_ready())  // Nothing moves on a stalled edge
  begin
    sel_now   = cur_sel();
    lock_now  = cur_lock();
    trans_now = cur_trans();
    m_edge_locked = lock_now && (m_lock || sel_now);
    if (sel_now && trans_now[ahb_out_pkg::HTRANS_ACTIVE_BIT] && lock_now)
      next_lock = 1'b1;    // Locked transfer taken here
    else if (!lock_now)
      next_lock = 1'b0;
    else
      next_lock = m_lock;
    m_data_port = m_grant; // Address phase becomes data phase
    m_slave_sel = sel_now;
    if (!m_edge_locked)
    begin
      cur   = port_index(m_grant);
      found = 1'b0;
      for (int k = 1; k <= 3; k++)
      begin
        cand = (cur + k) % 3;  // Search starts after the current owner
        if (!found && p_held[cand] && p_sel[cand])
        begin
          found   = 1'b1;
          m_grant = index_code(cand);
        end
      end
      m_no_port = !found;      // Grant code stays when idle
    end
    m_lock = next_lock;
  end
endtask

`endif

/* tb/tb_ahb_out_stage.sv */
`timescale 1ns/100ps

/* Random-stimulus testbench for the flash output stage. Port arrays use index
   0, 1, 2 for ports 0, 2, 3; the run stops at the first mismatch */
module tb_ahb_out_stage;

  localparam int RESET_CYCLES   = 8;
  localparam int RANDOM_CYCLES  = 400;   // Phase 1 mixed traffic with rare locks
  localparam int RR_CYCLES      = 400;   // Phase 2 with every port requesting
  localparam int LOCK_CYCLES    = 1200;  // Phase 3 with frequent lock runs
  localparam int TIMEOUT_CYCLES = 2100;  // All phases plus reset and margin

  logic                  HCLK;
  logic                  HRESETn;
  logic                  p_sel    [3];
  ahb_out_pkg::haddr_t   p_addr   [3];
  ahb_out_pkg::htrans_t  p_trans  [3];
  logic                  p_write  [3];
  ahb_out_pkg::hsize_t   p_size   [3];
  ahb_out_pkg::hburst_t  p_burst  [3];
  ahb_out_pkg::hprot_t   p_prot   [3];
  ahb_out_pkg::hmaster_t p_master [3];
  logic                  p_lock   [3];
  ahb_out_pkg::hdata_t   p_wdata  [3];
  logic                  p_held   [3];
  logic                  hready;          // Slave ready into the DUT
  logic [2:0]            active;          // {op3, op2, op0}
  logic                  o_hselm;
  logic                  o_hwritem;
  logic                  o_hmastlockm;
  logic                  o_hreadymuxm;
  ahb_out_pkg::haddr_t   o_haddrm;
  ahb_out_pkg::htrans_t  o_htransm;
  ahb_out_pkg::hsize_t   o_hsizem;
  ahb_out_pkg::hburst_t  o_hburstm;
  ahb_out_pkg::hprot_t   o_hprotm;
  ahb_out_pkg::hmaster_t o_hmasterm;
  ahb_out_pkg::hdata_t   o_hwdatam;
  int                    lock_left [3];   // Cycles left in each lock run
  int                    cycle_count = 0;
  int                    error_count = 0;
  string                 test_name;

  `include "ahb_out_model.svh"

  initial HCLK = 1'b0;
  always #5 HCLK = ~HCLK;  // 10 ns period

  ahb_out_stage u_dut (
    .HCLK            (HCLK),
    .HRESETn         (HRESETn),
    .i_sel_op0       (p_sel[0]),
    .i_addr_op0      (p_addr[0]),
    .i_trans_op0     (p_trans[0]),
    .i_write_op0     (p_write[0]),
    .i_size_op0      (p_size[0]),
    .i_burst_op0     (p_burst[0]),
    .i_prot_op0      (p_prot[0]),
    .i_master_op0    (p_master[0]),
    .i_mastlock_op0  (p_lock[0]),
    .i_wdata_op0     (p_wdata[0]),
    .i_held_tran_op0 (p_held[0]),
    .i_sel_op2       (p_sel[1]),
    .i_addr_op2      (p_addr[1]),
    .i_trans_op2     (p_trans[1]),
    .i_write_op2     (p_write[1]),
    .i_size_op2      (p_size[1]),
    .i_burst_op2     (p_burst[1]),
    .i_prot_op2      (p_prot[1]),
    .i_master_op2    (p_master[1]),
    .i_mastlock_op2  (p_lock[1]),
    .i_wdata_op2     (p_wdata[1]),
    .i_held_tran_op2 (p_held[1]),
    .i_sel_op3       (p_sel[2]),
    .i_addr_op3      (p_addr[2]),
    .i_trans_op3     (p_trans[2]),
    .i_write_op3     (p_write[2]),
    .i_size_op3      (p_size[2]),
    .i_burst_op3     (p_burst[2]),
    .i_prot_op3      (p_prot[2]),
    .i_master_op3    (p_master[2]),
    .i_mastlock_op3  (p_lock[2]),
    .i_wdata_op3     (p_wdata[2]),
    .i_held_tran_op3 (p_held[2]),
    .i_hreadyoutm    (hready),
    .o_active_op0    (active[0]),
    .o_active_op2    (active[1]),
    .o_active_op3    (active[2]),
    .o_hselm         (o_hselm),
    .o_haddrm        (o_haddrm),
    .o_htransm       (o_htransm),
    .o_hwritem       (o_hwritem),
    .o_hsizem        (o_hsizem),
    .o_hburstm       (o_hburstm),
    .o_hprotm        (o_hprotm),
    .o_hmasterm      (o_hmasterm),
    .o_hmastlockm    (o_hmastlockm),
    .o_hreadymuxm    (o_hreadymuxm),
    .o_hwdatam       (o_hwdatam)
  );

  always @(posedge HCLK)
  begin
    cycle_count++;
    if (cycle_count > TIMEOUT_CYCLES)
    begin
      $display("Timeout after %0d cycles, the run did not reach its end", cycle_count);
      $display("Finished with errors");
      $fatal(1, "timeout");
    end
  end

  // ------------------------------------------------------------
  // Checks and stimulus
  // ------------------------------------------------------------
  task automatic check_value(input string what, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected)
    begin
      error_count++;
      $display("ERR %s %s: expected %h actual %h", test_name, what, expected, actual);
      $display("Finished with errors");
      $fatal(1, "stopped at the first mismatch");
    end
  endtask

  task automatic drive_inputs(input int phase);
    int lock_odds;
    lock_odds = (phase == 3) ? 16 : 64;
    for (int p = 0; p < 3; p++)
    begin
      if (phase == 2)
        lock_left[p] = 0;                          // No locks in round robin
      else if (lock_left[p] > 0)
        lock_left[p]--;
      else if ($urandom % lock_odds == 0)
        lock_left[p] = 4 + int'($urandom % 16);    // Run of 4 to 19 cycles
      p_lock[p]   = lock_left[p] != 0;
      p_sel[p]    = (phase == 2) || ($urandom % 4 != 0);
      p_held[p]   = (phase == 2) || ($urandom % 2 == 0);
      p_addr[p]   = $urandom;
      p_trans[p]  = ahb_out_pkg::htrans_t'($urandom);
      p_write[p]  = $urandom % 2 == 0;
      p_size[p]   = ahb_out_pkg::hsize_t'($urandom);
      p_burst[p]  = ahb_out_pkg::hburst_t'($urandom);
      p_prot[p]   = ahb_out_pkg::hprot_t'($urandom);
      p_master[p] = ahb_out_pkg::hmaster_t'($urandom);
      p_wdata[p]  = $urandom;
    end
    hready = $urandom % 5 != 0;                    // Mostly ready
  endtask

  task automatic check_outputs();
    int   idx;
    logic on;
    idx = port_index(m_grant);
    on  = !m_no_port;
    check_value("active", 32'(exp_active()), 32'(active));
    check_value("o_hselm", 32'(cur_sel()), 32'(o_hselm));
    check_value("o_haddrm", on ? p_addr[idx] : 32'd0, o_haddrm);
    check_value("o_htransm", 32'(cur_trans()), 32'(o_htransm));
    check_value("o_hwritem", 32'(on && p_write[idx]), 32'(o_hwritem));
    check_value("o_hsizem", 32'(on ? p_size[idx] : 3'd0), 32'(o_hsizem));
    check_value("o_hburstm", 32'(on ? p_burst[idx] : 3'd0), 32'(o_hburstm));
    check_value("o_hprotm", 32'(on ? p_prot[idx] : 4'd0), 32'(o_hprotm));
    check_value("o_hmasterm", 32'(on ? p_master[idx] : 4'd0), 32'(o_hmasterm));
    check_value("o_hmastlockm", 32'(cur_lock()), 32'(o_hmastlockm));
    check_value("o_hreadymuxm", 32'(exp_ready()), 32'(o_hreadymuxm));
    check_value("o_hwdatam", p_wdata[port_index(m_data_port)], o_hwdatam);
  endtask

  task automatic run_cycle(input int phase, input int n);
    logic [2:0] prev_active;
    logic       edge_ready;
    prev_active = exp_active();
    edge_ready  = exp_ready();
    @(posedge HCLK);
    model_step();
    @(negedge HCLK);
    drive_inputs(phase);
    #1;
    // Owner stays across a stalled or locked edge
    if ((!edge_ready || m_edge_locked) && prev_active != 3'b000)
      check_value("grant hold", 32'(prev_active), 32'(active));
    // Order 0, 2, 3, 0 once all ports request
    if (phase == 2 && n > 0 && edge_ready && prev_active != 3'b000)
      check_value("round robin", 32'({prev_active[1:0], prev_active[2]}), 32'(active));
    check_outputs();
  endtask

  // ------------------------------------------------------------
  // Test sequence
  // ------------------------------------------------------------
  initial
  begin
    void'($urandom(32'h5a8c_d030));
    test_name = "reset";
    HRESETn   = 1'b0;
    drive_inputs(1);
    model_reset();
    repeat (RESET_CYCLES) @(posedge HCLK);
    @(negedge HCLK);
    HRESETn = 1'b1;
    #1;
    check_value("active", 32'd0, 32'(active));
    check_value("o_hselm", 32'd0, 32'(o_hselm));
    check_value("o_hreadymuxm", 32'd1, 32'(o_hreadymuxm));
    test_name = "random";
    for (int i = 0; i < RANDOM_CYCLES; i++)
      run_cycle(1, i);
    test_name = "round_robin";
    for (int i = 0; i < RR_CYCLES; i++)
      run_cycle(2, i);
    test_name = "lock_mix";
    for (int i = 0; i < LOCK_CYCLES; i++)
      run_cycle(3, i);
    if (error_count == 0)
    begin
      $display("Finished with no errors");
      $finish;
    end
    else
    begin
      $display("Finished with errors");
      $fatal(1, "checks failed");
    end
  end

endmodule
